// ==== hw/stall_prof_defines.svh ====
`ifndef STALL_PROF_DEFINES_SVH
`define STALL_PROF_DEFINES_SVH

// Reason bits carried through the pipe, index 0 has top priority
`define STALL_NUM_REASONS 19

// Width of each profiling counter, wraps on overflow
`define STALL_CNT_WIDTH 32

// Cycles, retired issues, one per reason, then unknown
`define STALL_NUM_COUNTERS (`STALL_NUM_REASONS + 3)

`endif

// ==== hw/stall_prof_pkg.sv ====
`include "stall_prof_defines.svh"

package stall_prof_pkg;

  // Named reason bits, listed from the top index down to index 0
  typedef struct packed {
    logic iq_full;
    logic ic_invl;
    logic ic_miss;
    logic ic_flush;
    logic ic_atrans;
    logic bp_haz;
    logic ireplay;
    logic realign;
    logic sb_full;
    logic waw_haz;
    logic fu_busy;
    logic raw_haz;
    logic br_haz;
    logic mul_haz;
    logic br_miss;
    logic amo_flush;
    logic csr_flush;
    logic fence;
    logic exception;
  } stall_reason_s;

  // Same word seen as named bits or as a flat vector
  typedef union packed {
    stall_reason_s                 bits;
    logic [`STALL_NUM_REASONS-1:0] vec;
  } stall_reason_u;

  // I$ controller states
  typedef enum logic [2:0] {
    IC_FLUSH       = 3'd0,
    IC_IDLE        = 3'd1,
    IC_READ        = 3'd2,
    IC_MISS        = 3'd3,
    IC_KILL_ATRANS = 3'd4,
    IC_KILL_MISS   = 3'd5
  } icache_state_e;

  typedef logic [`STALL_NUM_COUNTERS-1:0][`STALL_CNT_WIDTH-1:0] prof_counters_t;

endpackage

// ==== hw/flush_if.sv ====
`timescale 1ns/1ps

interface flush_if;
  logic branch_mispredict;
  logic flush_amo;
  logic flush_csr;
  logic exception;
  // Unissued instructions dropped this cycle
  logic flush_unissued;

  modport source (
    output branch_mispredict, flush_amo, flush_csr, exception, flush_unissued
  );

  modport sink (
    input branch_mispredict, flush_amo, flush_csr, exception, flush_unissued
  );
endinterface

// ==== hw/icache_stall_decode.sv ====
`timescale 1ns/1ps

module icache_stall_decode (
  input  stall_prof_pkg::icache_state_e icache_state_q_i,
  input  stall_prof_pkg::icache_state_e icache_state_d_i,
  input  logic                          icache_hit_i,
  input  logic                          icache_flush_d_i,
  input  logic                          icache_rtrn_vld_i,
  input  logic                          ic_miss_i,
  output stall_prof_pkg::stall_reason_u ic_busy_o
);
  import stall_prof_pkg::*;

  logic in_read;
  logic busy_atrans;
  logic busy_flush;
  logic busy_miss;
  logic busy_invl;

  assign in_read = (icache_state_q_i == IC_READ);

  // Address translation pending, or a killed translation draining
  assign busy_atrans = (in_read && (icache_state_d_i inside {IC_READ, IC_KILL_ATRANS}) &&
                        !icache_hit_i) ||
                       (icache_state_q_i == IC_KILL_ATRANS);

  assign busy_flush = (in_read && icache_flush_d_i) || (icache_state_q_i == IC_FLUSH);

  assign busy_miss = (in_read && ic_miss_i) ||
                     (icache_state_q_i inside {IC_MISS, IC_KILL_MISS});

  // Refill return arriving while the cache wants to serve
  assign busy_invl = (icache_state_q_i inside {IC_IDLE, IC_READ}) && icache_rtrn_vld_i;

  // At most one reason, atrans first
  always_comb begin
    ic_busy_o = '0;
    if (busy_atrans) begin
      ic_busy_o.bits.ic_atrans = 1'b1;
    end else if (busy_flush) begin
      ic_busy_o.bits.ic_flush = 1'b1;
    end else if (busy_miss) begin
      ic_busy_o.bits.ic_miss = 1'b1;
    end else if (busy_invl) begin
      ic_busy_o.bits.ic_invl = 1'b1;
    end
  end

endmodule

// ==== hw/frontend_stall_pipe.sv ====
`timescale 1ns/1ps

module frontend_stall_pipe (
  input  logic                          clk_i,
  input  logic                          reset_i,
  flush_if.sink                         flush,
  input  stall_prof_pkg::stall_reason_u ic_busy_i,
  input  logic                          instr_queue_ready_i,
  input  logic                          instr_queue_valid_i,
  input  logic                          fe_bp_valid_i,
  input  logic                          fe_replay_i,
  input  logic                          fe_realign_bubble_i,
  output stall_prof_pkg::stall_reason_u flush_reason_o,
  output stall_prof_pkg::stall_reason_u id_reason_o
);
  import stall_prof_pkg::*;

  stall_reason_u flush_reason;
  stall_reason_u pc_n;
  stall_reason_u pc_r;
  stall_reason_u ic_n;
  stall_reason_u ic_r;
  stall_reason_u re_n;
  stall_reason_u re_r;
  stall_reason_u id_n;
  stall_reason_u id_r;

  // Flush classification, fence only when nothing else explains the flush
  always_comb begin
    flush_reason = '0;
    flush_reason.bits.br_miss   = flush.branch_mispredict;
    flush_reason.bits.amo_flush = flush.flush_amo;
    flush_reason.bits.csr_flush = flush.flush_csr;
    flush_reason.bits.exception = flush.exception;
    flush_reason.bits.fence     = flush.flush_unissued &
                                  ~(flush.branch_mispredict | flush.flush_amo |
                                    flush.flush_csr | flush.exception);
  end

  always_comb begin
    // PC generation
    pc_n = '0;
    pc_n.bits.iq_full = ~instr_queue_ready_i;
    pc_n.bits.bp_haz  = fe_bp_valid_i;
    pc_n.bits.ireplay = fe_replay_i;
    pc_n.vec = pc_n.vec | ic_busy_i.vec | flush_reason.vec;

    // I$ output, a busy cache overrides what came from PC gen
    ic_n = (|ic_busy_i.vec) ? ic_busy_i : pc_r;
    ic_n.bits.bp_haz  = ic_n.bits.bp_haz | fe_bp_valid_i;
    ic_n.bits.ireplay = ic_n.bits.ireplay | fe_replay_i;
    ic_n.vec = ic_n.vec | flush_reason.vec;

    // Instruction queue input
    re_n = ic_r;
    re_n.bits.realign = re_n.bits.realign | fe_realign_bubble_i;
    re_n.vec = re_n.vec | flush_reason.vec;

    // Decode sees nothing to blame when the queue hands out an instruction
    id_n = instr_queue_valid_i ? '0 : re_r;
    id_n.vec = id_n.vec | flush_reason.vec;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r <= '0;
      ic_r <= '0;
      re_r <= '0;
      id_r <= '0;
    end else begin
      pc_r <= pc_n;
      ic_r <= ic_n;
      re_r <= re_n;
      id_r <= id_n;
    end
  end

  assign flush_reason_o = flush_reason;
  assign id_reason_o    = id_r;

endmodule

// ==== hw/issue_stall_classify.sv ====
`timescale 1ns/1ps

module issue_stall_classify (
  input  stall_prof_pkg::stall_reason_u flush_reason_i,
  input  stall_prof_pkg::stall_reason_u id_reason_i,
  input  logic                          is_valid_i,
  input  logic                          is_ack_i,
  input  logic                          is_sb_full_i,
  input  logic                          is_unresolved_branch_i,
  input  logic                          ex_mul_valid_i,
  input  logic                          is_ro_stall_i,
  input  logic                          is_ro_fubusy_i,
  output stall_prof_pkg::stall_reason_u is_reason_o
);
  import stall_prof_pkg::*;

  logic          is_stall;
  logic          known_haz;
  stall_reason_u haz;

  // Instruction waiting at issue but not taken
  assign is_stall = is_valid_i & ~is_ack_i;

  assign known_haz = is_sb_full_i | is_unresolved_branch_i | ex_mul_valid_i |
                     is_ro_stall_i | is_ro_fubusy_i;

  always_comb begin
    haz = '0;
    haz.bits.sb_full = is_stall & is_sb_full_i;
    haz.bits.br_haz  = is_stall & is_unresolved_branch_i;
    haz.bits.mul_haz = is_stall & ex_mul_valid_i;
    haz.bits.raw_haz = is_stall & is_ro_stall_i;
    haz.bits.fu_busy = is_stall & is_ro_fubusy_i;
    // Residual case, assume a write-after-write conflict
    haz.bits.waw_haz = is_stall & ~known_haz;
  end

  assign is_reason_o = id_reason_i.vec | haz.vec | flush_reason_i.vec;

endmodule

// ==== hw/stall_counter_bank.sv ====
`timescale 1ns/1ps
`include "stall_prof_defines.svh"

module stall_counter_bank (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           en_i,
  input  logic                           is_ack_i,
  flush_if.sink                          flush,
  input  stall_prof_pkg::stall_reason_u  is_reason_i,
  output stall_prof_pkg::prof_counters_t counters_o
);
  import stall_prof_pkg::*;

  localparam int unsigned reason_base = 2;
  localparam int unsigned unknown_idx = `STALL_NUM_COUNTERS - 1;

  logic                           stall;
  logic [`STALL_NUM_REASONS-1:0]  first_reason;
  logic [`STALL_NUM_COUNTERS-1:0] cnt_inc;
  prof_counters_t                 cnt_r;

  // An acked issue only retires if it was not flushed in the same cycle
  assign stall = ~(is_ack_i & ~flush.flush_unissued);

  // Lowest set bit in one-hot form
  assign first_reason = is_reason_i.vec & (~is_reason_i.vec + 1'b1);

  always_comb begin
    cnt_inc = '0;
    cnt_inc[0] = en_i;
    cnt_inc[1] = en_i & ~stall;
    cnt_inc[reason_base +: `STALL_NUM_REASONS] = {`STALL_NUM_REASONS{en_i & stall}} &
                                                 first_reason;
    // Stall with no reason attached
    cnt_inc[unknown_idx] = en_i & stall & ~(|is_reason_i.vec);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r <= '0;
    end else begin
      for (int i = 0; i < `STALL_NUM_COUNTERS; i++) begin
        if (cnt_inc[i]) begin
          cnt_r[i] <= cnt_r[i] + `STALL_CNT_WIDTH'(1);
        end
      end
    end
  end

  assign counters_o = cnt_r;

endmodule

// ==== hw/stall_profiler.sv ====
`timescale 1ns/1ps

module stall_profiler (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           en_i,

  input  logic                           instr_queue_ready_i,
  input  logic                           instr_queue_valid_i,
  input  logic                           fe_bp_valid_i,
  input  logic                           fe_replay_i,
  input  logic                           fe_realign_bubble_i,

  input  logic [2:0]                     icache_state_q_i,
  input  logic [2:0]                     icache_state_d_i,
  input  logic                           icache_hit_i,
  input  logic                           icache_flush_d_i,
  input  logic                           icache_rtrn_vld_i,
  input  logic                           ic_miss_i,

  input  logic                           branch_mispredict_i,
  input  logic                           flush_amo_i,
  input  logic                           flush_csr_i,
  input  logic                           exception_i,
  input  logic                           flush_unissued_i,

  input  logic                           is_valid_i,
  input  logic                           is_ack_i,
  input  logic                           is_sb_full_i,
  input  logic                           is_unresolved_branch_i,
  input  logic                           ex_mul_valid_i,
  input  logic                           is_ro_stall_i,
  input  logic                           is_ro_fubusy_i,

  output stall_prof_pkg::prof_counters_t data_o
);
  import stall_prof_pkg::*;

  icache_state_e icache_state_q;
  icache_state_e icache_state_d;
  stall_reason_u ic_busy;
  stall_reason_u flush_reason;
  stall_reason_u id_reason;
  stall_reason_u is_reason;

  flush_if flush_bus ();

  assign flush_bus.branch_mispredict = branch_mispredict_i;
  assign flush_bus.flush_amo         = flush_amo_i;
  assign flush_bus.flush_csr         = flush_csr_i;
  assign flush_bus.exception         = exception_i;
  assign flush_bus.flush_unissued    = flush_unissued_i;

  assign icache_state_q = icache_state_e'(icache_state_q_i);
  assign icache_state_d = icache_state_e'(icache_state_d_i);

  icache_stall_decode icache_stall_decode_inst (
    .icache_state_q_i  (icache_state_q),
    .icache_state_d_i  (icache_state_d),
    .icache_hit_i      (icache_hit_i),
    .icache_flush_d_i  (icache_flush_d_i),
    .icache_rtrn_vld_i (icache_rtrn_vld_i),
    .ic_miss_i         (ic_miss_i),
    .ic_busy_o         (ic_busy)
  );

  frontend_stall_pipe frontend_stall_pipe_inst (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .flush               (flush_bus.sink),
    .ic_busy_i           (ic_busy),
    .instr_queue_ready_i (instr_queue_ready_i),
    .instr_queue_valid_i (instr_queue_valid_i),
    .fe_bp_valid_i       (fe_bp_valid_i),
    .fe_replay_i         (fe_replay_i),
    .fe_realign_bubble_i (fe_realign_bubble_i),
    .flush_reason_o      (flush_reason),
    .id_reason_o         (id_reason)
  );

  issue_stall_classify issue_stall_classify_inst (
    .flush_reason_i         (flush_reason),
    .id_reason_i            (id_reason),
    .is_valid_i             (is_valid_i),
    .is_ack_i               (is_ack_i),
    .is_sb_full_i           (is_sb_full_i),
    .is_unresolved_branch_i (is_unresolved_branch_i),
    .ex_mul_valid_i         (ex_mul_valid_i),
    .is_ro_stall_i          (is_ro_stall_i),
    .is_ro_fubusy_i         (is_ro_fubusy_i),
    .is_reason_o            (is_reason)
  );

  stall_counter_bank stall_counter_bank_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .en_i        (en_i),
    .is_ack_i    (is_ack_i),
    .flush       (flush_bus.sink),
    .is_reason_i (is_reason),
    .counters_o  (data_o)
  );

endmodule

// ==== bench/stall_profiler_tb.sv ====
`timescale 1ns/1ps
`include "stall_prof_defines.svh"

module stall_profiler_tb;
  import stall_prof_pkg::*;

  // Counter slots, reason counters sit at 2 plus the reason bit index
  localparam int cnt_cycles    = 0;
  localparam int cnt_retired   = 1;
  localparam int cnt_exception = 2;
  localparam int cnt_fence     = 3;
  localparam int cnt_br_miss   = 6;
  localparam int cnt_mul_haz   = 7;
  localparam int cnt_br_haz    = 8;
  localparam int cnt_raw_haz   = 9;
  localparam int cnt_fu_busy   = 10;
  localparam int cnt_waw_haz   = 11;
  localparam int cnt_sb_full   = 12;
  localparam int cnt_ic_atrans = 16;
  localparam int cnt_ic_flush  = 17;
  localparam int cnt_iq_full   = 20;
  localparam int cnt_unknown   = `STALL_NUM_COUNTERS - 1;
  // Limit well above the roughly 300 cycles of the tests
  localparam int max_cycles    = 2000;

  logic clk_i;
  logic reset_i;
  logic en_i;
  logic instr_queue_ready_i;
  logic instr_queue_valid_i;
  logic fe_bp_valid_i;
  logic fe_replay_i;
  logic fe_realign_bubble_i;
  logic [2:0] icache_state_q_i;
  logic [2:0] icache_state_d_i;
  logic icache_hit_i;
  logic icache_flush_d_i;
  logic icache_rtrn_vld_i;
  logic ic_miss_i;
  logic branch_mispredict_i;
  logic flush_amo_i;
  logic flush_csr_i;
  logic exception_i;
  logic flush_unissued_i;
  logic is_valid_i;
  logic is_ack_i;
  logic is_sb_full_i;
  logic is_unresolved_branch_i;
  logic ex_mul_valid_i;
  logic is_ro_stall_i;
  logic is_ro_fubusy_i;
  prof_counters_t data_o;

  prof_counters_t ref_cnt;
  logic [31:0] rng_state = 32'd27743;
  int cycle_count = 0;

  stall_profiler stall_profiler_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      report_failure("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      report_failure($sformatf("[ERROR] %s: expected 0x%08h, got 0x%08h",
                               name, expected, actual));
    end
  endtask

  // Inputs change 2 ns after the edge, outputs are read at the same point
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic compare_all();
    int i;
    for (i = 0; i < `STALL_NUM_COUNTERS; i++) begin
      check_value($sformatf("data_o[%0d]", i), ref_cnt[i], data_o[i]);
    end
  endtask

  // One cycle where the given counter should advance, -1 when en_i is low
  task automatic run_cycle(input int counted);
    if (counted >= 0) begin
      ref_cnt[cnt_cycles] = ref_cnt[cnt_cycles] + 32'd1;
      ref_cnt[counted] = ref_cnt[counted] + 32'd1;
    end
    next_cycle();
    compare_all();
  endtask

  // Queue flowing, I$ idle, nothing at issue
  task automatic set_idle();
    instr_queue_ready_i = 1'b1;
    instr_queue_valid_i = 1'b1;
    fe_bp_valid_i = 1'b0;
    fe_replay_i = 1'b0;
    fe_realign_bubble_i = 1'b0;
    icache_state_q_i = IC_IDLE;
    icache_state_d_i = IC_IDLE;
    icache_hit_i = 1'b0;
    icache_flush_d_i = 1'b0;
    icache_rtrn_vld_i = 1'b0;
    ic_miss_i = 1'b0;
    branch_mispredict_i = 1'b0;
    flush_amo_i = 1'b0;
    flush_csr_i = 1'b0;
    exception_i = 1'b0;
    flush_unissued_i = 1'b0;
    is_valid_i = 1'b0;
    is_ack_i = 1'b0;
    is_sb_full_i = 1'b0;
    is_unresolved_branch_i = 1'b0;
    ex_mul_valid_i = 1'b0;
    is_ro_stall_i = 1'b0;
    is_ro_fubusy_i = 1'b0;
  endtask

  task automatic drive_random();
    logic [31:0] a;
    logic [31:0] b;
    rng_state = xorshift(rng_state);
    a = rng_state;
    rng_state = xorshift(rng_state);
    b = rng_state;
    instr_queue_ready_i = a[0];
    instr_queue_valid_i = a[1];
    fe_bp_valid_i = a[2];
    fe_replay_i = a[3];
    fe_realign_bubble_i = a[4];
    icache_hit_i = a[5];
    icache_flush_d_i = a[6];
    icache_rtrn_vld_i = a[7];
    ic_miss_i = a[8];
    // Flushes are rarer than hazards
    branch_mispredict_i = a[9] & a[10];
    flush_amo_i = a[11] & a[12];
    flush_csr_i = a[13] & a[14];
    exception_i = a[15] & a[16];
    flush_unissued_i = a[17] & a[18];
    is_valid_i = a[19];
    is_ack_i = a[20];
    is_sb_full_i = a[21];
    is_unresolved_branch_i = a[22];
    ex_mul_valid_i = a[23];
    is_ro_stall_i = a[24];
    is_ro_fubusy_i = a[25];
    icache_state_q_i = 3'(b[15:0] % 16'd6);
    icache_state_d_i = 3'(b[31:16] % 16'd6);
  endtask

  // Every enabled cycle lands in exactly one of counters 1 to 21
  task automatic run_random_phase();
    int n;
    int i;
    logic [31:0] retired_base;
    logic [31:0] retired_seen;
    logic [31:0] sum;
    en_i = 1'b1;
    retired_base = ref_cnt[cnt_retired];
    retired_seen = '0;
    for (n = 0; n < 200; n++) begin
      drive_random();
      if (is_ack_i && !flush_unissued_i) begin
        retired_seen = retired_seen + 32'd1;
      end
      next_cycle();
      sum = '0;
      for (i = 1; i < `STALL_NUM_COUNTERS; i++) begin
        sum = sum + data_o[i];
      end
      check_value("sum of data_o[21:1]", data_o[cnt_cycles], sum);
      check_value("data_o[1]", retired_base + retired_seen, data_o[cnt_retired]);
    end
  endtask

  task automatic run_hazard_sweep();
    int combo;
    int exp_idx;
    set_idle();
    en_i = 1'b1;
    is_valid_i = 1'b1;
    for (combo = 0; combo < 32; combo++) begin
      is_sb_full_i = combo[0];
      is_unresolved_branch_i = combo[1];
      ex_mul_valid_i = combo[2];
      is_ro_stall_i = combo[3];
      is_ro_fubusy_i = combo[4];
      // Highest index first so the lowest set reason wins
      exp_idx = cnt_waw_haz;
      if (combo[0]) exp_idx = cnt_sb_full;
      if (combo[4]) exp_idx = cnt_fu_busy;
      if (combo[3]) exp_idx = cnt_raw_haz;
      if (combo[1]) exp_idx = cnt_br_haz;
      if (combo[2]) exp_idx = cnt_mul_haz;
      run_cycle(exp_idx);
    end
  endtask

  task automatic run_frontend_latency();
    set_idle();
    en_i = 1'b1;
    instr_queue_valid_i = 1'b0;
    run_cycle(cnt_unknown);
    instr_queue_ready_i = 1'b0;
    run_cycle(cnt_unknown);
    instr_queue_ready_i = 1'b1;
    repeat (3) run_cycle(cnt_unknown);
    // Reaches decode four cycles after the drop
    run_cycle(cnt_iq_full);
    repeat (2) run_cycle(cnt_unknown);
  endtask

  task automatic run_icache_case(input logic [2:0] next_state, input int exp_idx);
    set_idle();
    en_i = 1'b1;
    icache_state_q_i = IC_READ;
    icache_state_d_i = next_state;
    icache_flush_d_i = 1'b1;
    ic_miss_i = 1'b1;
    run_cycle(cnt_unknown);
    set_idle();
    instr_queue_valid_i = 1'b0;
    repeat (2) run_cycle(cnt_unknown);
    // I$ stage copy, then the copy that entered at PC gen
    run_cycle(exp_idx);
    run_cycle(exp_idx);
    repeat (3) run_cycle(cnt_unknown);
  endtask

  task automatic drain_retired();
    set_idle();
    is_ack_i = 1'b1;
    repeat (6) run_cycle(cnt_retired);
    set_idle();
  endtask

  task automatic run_flush_checks();
    set_idle();
    en_i = 1'b1;
    flush_unissued_i = 1'b1;
    repeat (3) run_cycle(cnt_fence);
    exception_i = 1'b1;
    run_cycle(cnt_exception);
    drain_retired();
    branch_mispredict_i = 1'b1;
    repeat (2) run_cycle(cnt_br_miss);
    drain_retired();
  endtask

  initial begin
    reset_i = 1'b1;
    en_i = 1'b0;
    set_idle();
    ref_cnt = '0;
    repeat (8) next_cycle();
    reset_i = 1'b0;
    compare_all();

    // Enable gating of cycles, unknown and retired
    repeat (2) run_cycle(-1);
    en_i = 1'b1;
    repeat (2) run_cycle(cnt_unknown);
    is_ack_i = 1'b1;
    run_cycle(cnt_retired);
    en_i = 1'b0;
    repeat (2) run_cycle(-1);
    en_i = 1'b1;
    run_cycle(cnt_retired);

    run_hazard_sweep();
    run_frontend_latency();
    run_icache_case(IC_READ, cnt_ic_atrans);
    run_icache_case(IC_KILL_ATRANS, cnt_ic_atrans);
    run_icache_case(IC_IDLE, cnt_ic_flush);
    run_flush_checks();
    run_random_phase();

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== stall_profiler.f ====
+incdir+hw
hw/stall_prof_pkg.sv
hw/flush_if.sv
hw/icache_stall_decode.sv
hw/frontend_stall_pipe.sv
hw/issue_stall_classify.sv
hw/stall_counter_bank.sv
hw/stall_profiler.sv
bench/stall_profiler_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module stall_profiler_tb \
  -f stall_profiler.f \
  -o stall_profiler_sim

# A failing check exits non-zero, the log decides the result
./obj_dir/stall_profiler_sim > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi

if ! grep -q ">>> PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
